// ==== common/flag_pkg.sv ====
// In-flight flag definitions

package flag_pkg;

  // physical register number width, 64 registers
  localparam int ADDR_WIDTH = 6;

  localparam int NUM_CLEAR = 2;
  localparam int NUM_READ = 2;

  typedef logic [ADDR_WIDTH-1:0] reg_addr_t;

  // sweep length, one entry per cycle
  function automatic int init_cycles(int addr_width);
    return 1 << addr_width;
  endfunction

  localparam int INIT_CYCLES = init_cycles(ADDR_WIDTH);

endpackage

// ==== common/flag_write_if.sv ====
// Flag write bus
`timescale 1ns/1ps

interface flag_write_if #(
  parameter int ADDR_WIDTH = flag_pkg::ADDR_WIDTH,
  parameter int NUM_CLEAR = flag_pkg::NUM_CLEAR
);

  // staged clears, one per clear port
  logic [NUM_CLEAR-1:0] clr_valid;
  logic [NUM_CLEAR-1:0][ADDR_WIDTH-1:0] clr_addr;

  // allocation, same cycle as presented
  logic alloc_valid;
  logic [ADDR_WIDTH-1:0] alloc_addr;

  // init sweep
  logic sweep_valid;
  logic [ADDR_WIDTH-1:0] sweep_addr;
  logic init_busy;

  modport writer (
    output clr_valid, clr_addr, alloc_valid, alloc_addr,
    output sweep_valid, sweep_addr, init_busy
  );

  modport store (
    input clr_valid, clr_addr, alloc_valid, alloc_addr, sweep_valid, sweep_addr
  );

  modport bypass (
    input clr_valid, clr_addr, init_busy
  );

endinterface

// ==== verilog/flag_write_stage.sv ====
// Flag write stage and init sweep
`timescale 1ns/1ps

module flag_write_stage #(
  parameter int ADDR_WIDTH = flag_pkg::ADDR_WIDTH,
  parameter int NUM_CLEAR = flag_pkg::NUM_CLEAR
) (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic [NUM_CLEAR-1:0]                 clr_valid,
  input  logic [NUM_CLEAR-1:0][ADDR_WIDTH-1:0] clr_addr,
  input  logic                                 alloc_valid,
  input  logic [ADDR_WIDTH-1:0]                alloc_addr,
  flag_write_if.writer                         wr
);

  localparam int LAST_ENTRY = flag_pkg::init_cycles(ADDR_WIDTH) - 1;

  logic [NUM_CLEAR-1:0]                 clr_valid_q;
  logic [NUM_CLEAR-1:0][ADDR_WIDTH-1:0] clr_addr_q;
  logic [ADDR_WIDTH-1:0]                sweep_cnt;
  logic                                 busy;

  // clear strobes, one cycle behind the ports
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      clr_valid_q <= '0;
    end
    else
    begin
      clr_valid_q <= clr_valid;
    end
  end

  always_ff @(posedge clk)
  begin
    clr_addr_q <= clr_addr;
  end

  // sweep from entry 0 upward, busy drops after the last one
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      sweep_cnt <= '0;
      busy <= 1'b1;
    end
    else if (busy)
    begin
      sweep_cnt <= sweep_cnt + 1'b1;
      if (sweep_cnt == ADDR_WIDTH'(LAST_ENTRY))
      begin
        busy <= 1'b0;
      end
    end
  end

  assign wr.clr_valid = clr_valid_q;
  assign wr.clr_addr = clr_addr_q;

  // allocations go straight to storage
  assign wr.alloc_valid = alloc_valid;
  assign wr.alloc_addr = alloc_addr;

  assign wr.sweep_valid = busy;
  assign wr.sweep_addr = sweep_cnt;
  assign wr.init_busy = busy;

  // the core stays quiet until the array is initialized
  a_quiet_during_init: assert property (
    @(posedge clk) disable iff (rst)
    busy |-> !(|clr_valid) && !alloc_valid
  );

endmodule

// ==== verilog/flag_store.sv ====
// In-flight flag array
`timescale 1ns/1ps

module flag_store #(
  parameter int ADDR_WIDTH = flag_pkg::ADDR_WIDTH,
  parameter int NUM_READ = flag_pkg::NUM_READ
) (
  input  logic                                clk,
  flag_write_if.store                         wr,
  input  logic [NUM_READ-1:0][ADDR_WIDTH-1:0] rd_addr,
  output logic [NUM_READ-1:0]                 rd_flag
);

  localparam int DEPTH = 1 << ADDR_WIDTH;
  localparam int NUM_CLR = $bits(wr.clr_valid);

  // 1 means result still in flight
  logic [DEPTH-1:0] flags;

  // later writes win: sweep, then clears, then allocation
  always_ff @(posedge clk)
  begin
    if (wr.sweep_valid)
    begin
      flags[wr.sweep_addr] <= 1'b0;
    end
    for (int i = 0; i < NUM_CLR; i++)
    begin
      if (wr.clr_valid[i])
      begin
        flags[wr.clr_addr[i]] <= 1'b0;
      end
    end
    if (wr.alloc_valid)
    begin
      flags[wr.alloc_addr] <= 1'b1;
    end
  end

  for (genvar p = 0; p < NUM_READ; p++)
  begin : g_rd
    assign rd_flag[p] = flags[rd_addr[p]];
  end

  // two writeback ports never retire the same register together
  for (genvar i = 0; i < NUM_CLR; i++)
  begin : g_clr_a
    for (genvar j = i + 1; j < NUM_CLR; j++)
    begin : g_clr_b
      a_clr_distinct: assert property (
        @(posedge clk)
        wr.clr_valid[i] && wr.clr_valid[j] |-> wr.clr_addr[i] != wr.clr_addr[j]
      );
    end
  end

endmodule

// ==== verilog/flag_read_port.sv ====
// Flag read port with clear bypass
`timescale 1ns/1ps

module flag_read_port #(
  parameter int ADDR_WIDTH = flag_pkg::ADDR_WIDTH,
  parameter int NUM_CLEAR = flag_pkg::NUM_CLEAR
) (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               read_clk_en,
  input  logic [ADDR_WIDTH-1:0]              read_addr,
  input  logic                               read_const,
  // {valid, addr} of each clear port as presented
  input  logic [NUM_CLEAR-1:0][ADDR_WIDTH:0] live_clr,
  output logic [ADDR_WIDTH-1:0]              store_addr,
  input  logic                               store_flag,
  flag_write_if.bypass                       bypass,
  output logic                               read_data
);

  logic [ADDR_WIDTH-1:0] addr_q;
  logic                  const_q;
  logic                  init_q;
  logic                  clr_hit;

  // init_q comes out of reset set, array contents are unknown until swept
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      addr_q <= '0;
      const_q <= 1'b0;
      init_q <= 1'b1;
    end
    else if (read_clk_en)
    begin
      addr_q <= read_addr;
      const_q <= read_const;
      init_q <= bypass.init_busy;
    end
  end

  assign store_addr = addr_q;

  // a clear reads 0 while live and while staged
  always_comb
  begin
    clr_hit = 1'b0;
    for (int c = 0; c < NUM_CLEAR; c++)
    begin
      if (live_clr[c][ADDR_WIDTH] && live_clr[c][ADDR_WIDTH-1:0] == addr_q)
      begin
        clr_hit = 1'b1;
      end
      if (bypass.clr_valid[c] && bypass.clr_addr[c] == addr_q)
      begin
        clr_hit = 1'b1;
      end
    end
  end

  assign read_data = store_flag & ~clr_hit & ~const_q & ~init_q;

  // once swept every entry holds a known value
  a_known_after_init: assert property (
    @(posedge clk) disable iff (rst)
    !bypass.init_busy |-> !$isunknown(read_data)
  );

endmodule

// ==== verilog/inflight_flags.sv ====
// Register in-flight flag file
`timescale 1ns/1ps

module inflight_flags #(
  parameter int ADDR_WIDTH = $bits(flag_pkg::reg_addr_t),
  parameter int NUM_CLEAR = flag_pkg::NUM_CLEAR,
  parameter int NUM_READ = flag_pkg::NUM_READ
) (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic [NUM_CLEAR-1:0]                 clr_valid,
  input  logic [NUM_CLEAR-1:0][ADDR_WIDTH-1:0] clr_addr,
  input  logic                                 alloc_valid,
  input  logic [ADDR_WIDTH-1:0]                alloc_addr,
  input  logic                                 read_clk_en,
  input  logic [NUM_READ-1:0][ADDR_WIDTH-1:0]  read_addr,
  input  logic [NUM_READ-1:0]                  read_const,
  output logic [NUM_READ-1:0]                  read_data,
  output logic                                 init_busy
);

  logic [NUM_READ-1:0][ADDR_WIDTH-1:0] store_addr;
  logic [NUM_READ-1:0]                 store_flag;
  logic [NUM_CLEAR-1:0][ADDR_WIDTH:0]  live_clr;

  flag_write_if #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .NUM_CLEAR  (NUM_CLEAR)
  ) wr_bus ();

  flag_write_stage #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .NUM_CLEAR  (NUM_CLEAR)
  ) i_write_stage (
    .clk         (clk),
    .rst         (rst),
    .clr_valid   (clr_valid),
    .clr_addr    (clr_addr),
    .alloc_valid (alloc_valid),
    .alloc_addr  (alloc_addr),
    .wr          (wr_bus.writer)
  );

  flag_store #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .NUM_READ   (NUM_READ)
  ) i_store (
    .clk     (clk),
    .wr      (wr_bus.store),
    .rd_addr (store_addr),
    .rd_flag (store_flag)
  );

  for (genvar c = 0; c < NUM_CLEAR; c++)
  begin : g_live
    assign live_clr[c] = {clr_valid[c], clr_addr[c]};
  end

  for (genvar p = 0; p < NUM_READ; p++)
  begin : g_port
    flag_read_port #(
      .ADDR_WIDTH (ADDR_WIDTH),
      .NUM_CLEAR  (NUM_CLEAR)
    ) i_read_port (
      .clk         (clk),
      .rst         (rst),
      .read_clk_en (read_clk_en),
      .read_addr   (read_addr[p]),
      .read_const  (read_const[p]),
      .live_clr    (live_clr),
      .store_addr  (store_addr[p]),
      .store_flag  (store_flag[p]),
      .bypass      (wr_bus.bypass),
      .read_data   (read_data[p])
    );
  end

  assign init_busy = wr_bus.init_busy;

endmodule

// ==== sim/flag_checker.sv ====
// In-flight flag output checker
`timescale 1ns/1ps

module flag_checker #(
  parameter int NUM_READ = flag_pkg::NUM_READ,
  parameter int CHECK_DELAY = 36
) (
  input  logic                clk,
  input  logic                check_en,
  input  logic [NUM_READ-1:0] read_data,
  input  logic                init_busy,
  input  logic [NUM_READ-1:0] exp_data,
  input  logic                exp_init
);

  string test_name = "none";
  int    test_checks = 0;
  int    test_errors = 0;
  int    tests_done = 0;
  int    total_checks = 0;
  int    total_errors = 0;

  task automatic open_test(input string name);
    test_name = name;
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic close_test();
    $display("test %s: %0d checks, %0d errors", test_name, test_checks, test_errors);
    tests_done++;
    total_checks += test_checks;
    total_errors += test_errors;
  endtask

  task automatic report_totals();
    $display("%0d tests, %0d checks, %0d errors", tests_done, total_checks, total_errors);
  endtask

  task automatic compare_bit(input string what, input logic expected, input logic actual);
    test_checks++;
    if (actual !== expected)
    begin
      test_errors++;
      $display("CHECK FAILED %s %s: expected %b actual %b", test_name, what, expected, actual);
    end
  endtask

  // sample late in the cycle, inputs change just after the edge
  initial
  begin
    forever
    begin
      @(posedge clk);
      #(CHECK_DELAY);
      if (check_en)
      begin
        compare_bit("init_busy", exp_init, init_busy);
        for (int p = 0; p < NUM_READ; p++)
        begin
          compare_bit($sformatf("read_data[%0d]", p), exp_data[p], read_data[p]);
        end
      end
    end
  end

endmodule

// ==== sim/inflight_flags_tb.sv ====
// In-flight flag file testbench
`timescale 1ns/1ps

module inflight_flags_tb;

  localparam int ADDR_WIDTH = flag_pkg::ADDR_WIDTH;
  localparam int NUM_CLEAR = flag_pkg::NUM_CLEAR;
  localparam int NUM_READ = flag_pkg::NUM_READ;
  localparam int INIT_CYCLES = flag_pkg::INIT_CYCLES;
  localparam int CLK_PERIOD = 40;
  localparam int RESET_CYCLES = 10;
  // directed tests plus 300 random cycles
  localparam int TEST_CYCLES = 400;
  localparam int MAX_CYCLES = 2 * (RESET_CYCLES + INIT_CYCLES + TEST_CYCLES);

  logic                                 clk;
  logic                                 rst;
  logic [NUM_CLEAR-1:0]                 clr_valid;
  logic [NUM_CLEAR-1:0][ADDR_WIDTH-1:0] clr_addr;
  logic                                 alloc_valid;
  flag_pkg::reg_addr_t                  alloc_addr;
  logic                                 read_clk_en;
  logic [NUM_READ-1:0][ADDR_WIDTH-1:0]  read_addr;
  logic [NUM_READ-1:0]                  read_const;
  logic [NUM_READ-1:0]                  read_data;
  logic                                 init_busy;

  // reference model and captured read state
  logic                model [INIT_CYCLES];
  int                  last_clear [INIT_CYCLES];
  flag_pkg::reg_addr_t cap_addr [NUM_READ];
  logic                cap_const [NUM_READ];
  logic                cap_init [NUM_READ];
  int                  cycle;
  int                  cycle_count;
  integer              seed;
  logic                check_en;
  logic [NUM_READ-1:0] exp_data;
  logic                exp_init;

  inflight_flags #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .NUM_CLEAR  (NUM_CLEAR),
    .NUM_READ   (NUM_READ)
  ) i_inflight_flags (
    .clk         (clk),
    .rst         (rst),
    .clr_valid   (clr_valid),
    .clr_addr    (clr_addr),
    .alloc_valid (alloc_valid),
    .alloc_addr  (alloc_addr),
    .read_clk_en (read_clk_en),
    .read_addr   (read_addr),
    .read_const  (read_const),
    .read_data   (read_data),
    .init_busy   (init_busy)
  );

  flag_checker #(
    .NUM_READ    (NUM_READ),
    .CHECK_DELAY (CLK_PERIOD - 4)
  ) i_checker (
    .clk       (clk),
    .check_en  (check_en),
    .read_data (read_data),
    .init_busy (init_busy),
    .exp_data  (exp_data),
    .exp_init  (exp_init)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial
  begin
    cycle_count = 0;
    while (cycle_count < MAX_CYCLES)
    begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: tests still running after %0d cycles", MAX_CYCLES);
    $display("Simulation finished: FAIL");
    $finish;
  end

  function automatic flag_pkg::reg_addr_t random_addr();
    int r;
    r = $random(seed);
    return r[ADDR_WIDTH-1:0];
  endfunction

  // model entry after live clears unless the capture was constant or during init
  function automatic logic expected_read(input flag_pkg::reg_addr_t addr,
                                         input logic is_const, input logic in_init);
    logic flag;
    if (is_const || in_init)
    begin
      return 1'b0;
    end
    flag = model[addr];
    for (int c = 0; c < NUM_CLEAR; c++)
    begin
      if (clr_valid[c] && clr_addr[c] == addr)
      begin
        flag = 1'b0;
      end
    end
    return flag;
  endfunction

  // apply what was presented at the edge just passed
  task automatic take_edge();
    for (int c = 0; c < NUM_CLEAR; c++)
    begin
      if (clr_valid[c])
      begin
        model[clr_addr[c]] = 1'b0;
        last_clear[clr_addr[c]] = cycle;
      end
    end
    if (alloc_valid)
    begin
      model[alloc_addr] = 1'b1;
    end
    if (read_clk_en)
    begin
      for (int p = 0; p < NUM_READ; p++)
      begin
        cap_addr[p] = read_addr[p];
        cap_const[p] = read_const[p];
        cap_init[p] = exp_init;
      end
    end
    cycle++;
  endtask

  // publish expectations and step to just past the next edge
  task automatic tick();
    exp_init = cycle < INIT_CYCLES;
    for (int p = 0; p < NUM_READ; p++)
    begin
      exp_data[p] = expected_read(cap_addr[p], cap_const[p], cap_init[p]);
    end
    check_en = 1'b1;
    @(posedge clk);
    #2;
    take_edge();
    clr_valid = '0;
    alloc_valid = 1'b0;
  endtask

  task automatic alloc(input flag_pkg::reg_addr_t r);
    alloc_valid = 1'b1;
    alloc_addr = r;
  endtask

  task automatic retire(input int port, input flag_pkg::reg_addr_t r);
    clr_valid[port] = 1'b1;
    clr_addr[port] = r;
  endtask

  task automatic read_at(input flag_pkg::reg_addr_t a0, input flag_pkg::reg_addr_t a1);
    read_addr[0] = a0;
    read_addr[1] = a1;
  endtask

  // no allocation within two cycles of a clear and no two clears on one register
  task automatic random_cycle();
    flag_pkg::reg_addr_t r;
    read_clk_en = ($random(seed) & 3) != 0;
    read_at(random_addr(), random_addr());
    for (int p = 0; p < NUM_READ; p++)
    begin
      read_const[p] = ($random(seed) & 7) == 0;
    end
    r = random_addr();
    if (($random(seed) & 3) == 0 && cycle - last_clear[r] > 2)
    begin
      alloc(r);
    end
    for (int c = 0; c < NUM_CLEAR; c++)
    begin
      r = random_addr();
      if (($random(seed) & 3) == 0 && !(alloc_valid && alloc_addr == r)
          && !(c > 0 && clr_valid[0] && clr_addr[0] == r))
      begin
        retire(c, r);
      end
    end
  endtask

  initial
  begin
    seed = 32'h874f_27fb;
    rst = 1'b1;
    clr_valid = '0;
    clr_addr = '0;
    alloc_valid = 1'b0;
    alloc_addr = '0;
    read_clk_en = 1'b0;
    read_addr = '0;
    read_const = '0;
    check_en = 1'b0;
    exp_data = '0;
    exp_init = 1'b1;
    cycle = 0;
    for (int i = 0; i < INIT_CYCLES; i++)
    begin
      model[i] = 1'b0;
      last_clear[i] = -100;
    end
    for (int p = 0; p < NUM_READ; p++)
    begin
      cap_addr[p] = '0;
      cap_const[p] = 1'b0;
      cap_init[p] = 1'b1;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst = 1'b0;

    i_checker.open_test("init");
    repeat (INIT_CYCLES + 2)
    begin
      read_clk_en = ($random(seed) & 1) != 0;
      read_at(random_addr(), random_addr());
      tick();
    end
    i_checker.close_test();

    i_checker.open_test("alloc");
    read_clk_en = 1'b1;
    read_at(5, 40);
    alloc(5);
    tick();
    alloc(40);
    tick();
    read_at(6, 41);
    repeat (2) tick();
    i_checker.close_test();

    // zero while live, while staged, and after
    i_checker.open_test("clear");
    read_at(5, 40);
    repeat (2) tick();
    retire(0, 5);
    tick();
    retire(1, 40);
    tick();
    repeat (3) tick();
    i_checker.close_test();

    i_checker.open_test("const");
    alloc(12);
    read_at(12, 12);
    read_const = 2'b01;
    repeat (3) tick();
    read_const = '0;
    repeat (2) tick();
    i_checker.close_test();

    i_checker.open_test("hold");
    read_at(20, 21);
    tick();
    read_clk_en = 1'b0;
    read_at(30, 31);
    alloc(20);
    tick();
    alloc(21);
    read_at(0, 1);
    tick();
    retire(0, 20);
    tick();
    read_at(63, 62);
    repeat (2) tick();
    read_clk_en = 1'b1;
    repeat (2) tick();
    i_checker.close_test();

    i_checker.open_test("random");
    repeat (300)
    begin
      random_cycle();
      tick();
    end
    i_checker.close_test();

    i_checker.report_totals();
    if (i_checker.total_errors == 0)
    begin
      $display("Simulation finished: PASS");
    end
    else
    begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
common/flag_pkg.sv
common/flag_write_if.sv
verilog/flag_write_stage.sv
verilog/flag_store.sv
verilog/flag_read_port.sv
verilog/inflight_flags.sv
sim/flag_checker.sv
sim/inflight_flags_tb.sv
